//--- verilog/xbar_pkg.sv
package xbar_pkg;

    // transaction opcode, shared by master and slave sides
    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_e;

    // per-master read tracking
    // only one read may be in flight per master
    typedef enum logic {
        MST_IDLE      = 1'b0,
        MST_WAIT_RESP = 1'b1
    } master_state_e;

endpackage

//--- verilog/xbar_rr_arbiter.sv
`timescale 1ns/100ps

module xbar_rr_arbiter #(
    parameter int N_MASTERS = 4
)(
    input  logic                         clk,
    input  logic                         resetn,
    input  logic [N_MASTERS-1:0]         request,
    input  logic                         advance,
    output logic [N_MASTERS-1:0]         grant,
    output logic [$clog2(N_MASTERS)-1:0] grant_idx
);

    localparam int IDX_W = $clog2(N_MASTERS);

    logic [IDX_W-1:0]       base;
    logic [2*N_MASTERS-1:0] wide_req;
    logic [2*N_MASTERS-1:0] wide_grant;
    logic [N_MASTERS-1:0]   rot_req;
    logic [N_MASTERS-1:0]   rot_grant;

    always_comb begin
        // rotate so the base master sits at bit 0
        wide_req  = {request, request} >> base;
        rot_req   = wide_req[N_MASTERS-1:0];
        // isolate lowest set bit
        rot_grant = rot_req & (~rot_req + 1'b1);
        // undo the rotation
        wide_grant = {rot_grant, rot_grant} << base;
        grant      = wide_grant[2*N_MASTERS-1:N_MASTERS];

        grant_idx = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            if (grant[m]) begin
                grant_idx = IDX_W'(m);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            base <= '0;
        end else if (advance) begin
            base <= (base == IDX_W'(N_MASTERS - 1)) ? '0 : base + 1'b1;
        end
    end

    a_grant_ok: assert property (@(posedge clk) disable iff (!resetn)
        (request == '0) ? (grant == '0) :
                          ($onehot(grant) && ((grant & ~request) == '0)))
        else $error("bad grant %b for request %b", grant, request);

endmodule

//--- verilog/xbar_id_fifo.sv
`timescale 1ns/100ps

module xbar_id_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 2
)(
    input  logic             clk,
    input  logic             resetn,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn) push |-> !full)
        else $error("index fifo overflow");

    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn) pop |-> !empty)
        else $error("index fifo underflow");

endmodule

//--- verilog/xbar_decode.sv
`timescale 1ns/100ps

module xbar_decode import xbar_pkg::*; #(
    parameter int N_MASTERS  = 4,
    parameter int N_SLAVES   = 4,
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
)(
    input  logic                                         clk,
    input  logic                                         resetn,
    input  logic [N_MASTERS-1:0]                         master_req,
    input  logic [N_MASTERS-1:0][ADDR_WIDTH-1:0]         master_addr,
    input  cmd_e [N_MASTERS-1:0]                         master_cmd,
    input  logic [N_MASTERS-1:0][DATA_WIDTH-1:0]         master_wdata,
    input  logic [N_MASTERS-1:0]                         pend_take,
    input  logic [N_MASTERS-1:0]                         master_resp,
    output logic [N_MASTERS-1:0]                         master_ack,
    output logic [N_MASTERS-1:0]                         pend_valid,
    output logic [N_MASTERS-1:0][$clog2(N_SLAVES)-1:0]   pend_sid,
    output logic [N_MASTERS-1:0][ADDR_WIDTH-1:0]         pend_addr,
    output cmd_e [N_MASTERS-1:0]                         pend_cmd,
    output logic [N_MASTERS-1:0][DATA_WIDTH-1:0]         pend_wdata
);

    localparam int SID_W = $clog2(N_SLAVES);

    master_state_e [N_MASTERS-1:0] mst_state;

    // accept when idle and the holding slot is empty or leaving this cycle
    always_comb begin
        for (int m = 0; m < N_MASTERS; m++) begin
            master_ack[m] = master_req[m] && (mst_state[m] == MST_IDLE) &&
                            (!pend_valid[m] || pend_take[m]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int m = 0; m < N_MASTERS; m++) begin
                pend_valid[m] <= 1'b0;
                mst_state[m]  <= MST_IDLE;
            end
        end else begin
            for (int m = 0; m < N_MASTERS; m++) begin
                if (master_ack[m]) begin
                    pend_valid[m] <= 1'b1;
                end else if (pend_take[m]) begin
                    pend_valid[m] <= 1'b0;
                end

                // response cannot land in the accept cycle of the same read
                if (master_ack[m] && master_cmd[m] == CMD_READ) begin
                    mst_state[m] <= MST_WAIT_RESP;
                end else if (master_resp[m]) begin
                    mst_state[m] <= MST_IDLE;
                end
            end
        end
    end

    // request payload, slave index taken from the top address bits
    always_ff @(posedge clk) begin
        for (int m = 0; m < N_MASTERS; m++) begin
            if (master_ack[m]) begin
                pend_sid[m]   <= master_addr[m][ADDR_WIDTH-1 -: SID_W];
                pend_addr[m]  <= master_addr[m];
                pend_cmd[m]   <= master_cmd[m];
                pend_wdata[m] <= master_wdata[m];
            end
        end
    end

    for (genvar m = 0; m < N_MASTERS; m++) begin : gen_chk
        // an accepted read blocks further acks until its response comes back
        a_one_read: assert property (@(posedge clk) disable iff (!resetn)
            (master_ack[m] && master_cmd[m] == CMD_READ) |=>
                (!master_ack[m] until_with master_resp[m]))
            else $error("master %0d acked while a read is outstanding", m);
    end

endmodule

//--- verilog/xbar_execute.sv
`timescale 1ns/100ps

module xbar_execute import xbar_pkg::*; #(
    parameter int N_MASTERS  = 4,
    parameter int N_SLAVES   = 4,
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
)(
    input  logic                                         clk,
    input  logic                                         resetn,
    input  logic [N_MASTERS-1:0]                         pend_valid,
    input  logic [N_MASTERS-1:0][$clog2(N_SLAVES)-1:0]   pend_sid,
    input  logic [N_MASTERS-1:0][ADDR_WIDTH-1:0]         pend_addr,
    input  cmd_e [N_MASTERS-1:0]                         pend_cmd,
    input  logic [N_MASTERS-1:0][DATA_WIDTH-1:0]         pend_wdata,
    input  logic [N_SLAVES-1:0]                          slave_ack,
    output logic [N_MASTERS-1:0]                         pend_take,
    output logic [N_SLAVES-1:0]                          slave_req,
    output logic [N_SLAVES-1:0][ADDR_WIDTH-1:0]          slave_addr,
    output cmd_e [N_SLAVES-1:0]                          slave_cmd,
    output logic [N_SLAVES-1:0][DATA_WIDTH-1:0]          slave_wdata,
    output logic [N_SLAVES-1:0][$clog2(N_MASTERS)-1:0]   issue_mid
);

    localparam int SID_W = $clog2(N_SLAVES);
    localparam int MID_W = $clog2(N_MASTERS);

    logic [N_SLAVES-1:0][N_MASTERS-1:0] req_vec;
    logic [N_SLAVES-1:0][N_MASTERS-1:0] grant;
    logic [N_SLAVES-1:0][MID_W-1:0]     grant_idx;
    logic [N_SLAVES-1:0]                advance;

    always_comb begin
        pend_take = '0;
        for (int s = 0; s < N_SLAVES; s++) begin
            for (int m = 0; m < N_MASTERS; m++) begin
                req_vec[s][m] = pend_valid[m] && (pend_sid[m] == SID_W'(s));
            end
            // slave register free, or emptied at this edge
            advance[s] = (|req_vec[s]) && (!slave_req[s] || slave_ack[s]);
            if (advance[s]) begin
                pend_take = pend_take | grant[s];
            end
        end
    end

    for (genvar s = 0; s < N_SLAVES; s++) begin : gen_arb
        xbar_rr_arbiter #(
            .N_MASTERS (N_MASTERS)
        ) u_arb (
            .clk       (clk),
            .resetn    (resetn),
            .request   (req_vec[s]),
            .advance   (advance[s]),
            .grant     (grant[s]),
            .grant_idx (grant_idx[s])
        );

        a_hold: assert property (@(posedge clk) disable iff (!resetn)
            (slave_req[s] && !slave_ack[s]) |=>
                (slave_req[s] && $stable(slave_addr[s]) && $stable(slave_cmd[s])))
            else $error("slave %0d request changed before ack", s);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            slave_req <= '0;
        end else begin
            for (int s = 0; s < N_SLAVES; s++) begin
                if (advance[s]) begin
                    slave_req[s] <= 1'b1;
                end else if (slave_ack[s]) begin
                    slave_req[s] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < N_SLAVES; s++) begin
            if (advance[s]) begin
                slave_addr[s]  <= pend_addr[grant_idx[s]];
                slave_cmd[s]   <= pend_cmd[grant_idx[s]];
                slave_wdata[s] <= pend_wdata[grant_idx[s]];
                issue_mid[s]   <= grant_idx[s];
            end
        end
    end

endmodule

//--- verilog/xbar_result.sv
`timescale 1ns/100ps

module xbar_result import xbar_pkg::*; #(
    parameter int N_MASTERS  = 4,
    parameter int N_SLAVES   = 4,
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 4
)(
    input  logic                                         clk,
    input  logic                                         resetn,
    input  logic [N_SLAVES-1:0]                          slave_req,
    input  logic [N_SLAVES-1:0]                          slave_ack,
    input  cmd_e [N_SLAVES-1:0]                          slave_cmd,
    input  logic [N_SLAVES-1:0][$clog2(N_MASTERS)-1:0]   issue_mid,
    input  logic [N_SLAVES-1:0]                          slave_resp,
    input  logic [N_SLAVES-1:0][DATA_WIDTH-1:0]          slave_rdata,
    output logic [N_MASTERS-1:0]                         master_resp,
    output logic [N_MASTERS-1:0][DATA_WIDTH-1:0]         master_rdata
);

    localparam int MID_W = $clog2(N_MASTERS);

    logic [N_SLAVES-1:0][MID_W-1:0]     head_mid;
    logic [N_SLAVES-1:0]                fifo_empty;
    logic [N_MASTERS-1:0][N_SLAVES-1:0] hit;

    for (genvar s = 0; s < N_SLAVES; s++) begin : gen_fifo
        // remember who issued each read, in slave ack order
        xbar_id_fifo #(
            .DEPTH     (FIFO_DEPTH),
            .WIDTH     (MID_W)
        ) u_fifo (
            .clk       (clk),
            .resetn    (resetn),
            .push      (slave_req[s] && slave_ack[s] && slave_cmd[s] == CMD_READ),
            .push_data (issue_mid[s]),
            .pop       (slave_resp[s]),
            .head_data (head_mid[s]),
            .empty     (fifo_empty[s])
        );
    end

    always_comb begin
        master_resp  = '0;
        master_rdata = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            for (int s = 0; s < N_SLAVES; s++) begin
                hit[m][s] = slave_resp[s] && !fifo_empty[s] && (head_mid[s] == MID_W'(m));
                if (hit[m][s]) begin
                    master_resp[m]  = 1'b1;
                    master_rdata[m] = slave_rdata[s];
                end
            end
        end
    end

    for (genvar m = 0; m < N_MASTERS; m++) begin : gen_chk
        // holds only because decode allows one outstanding read per master
        a_single_src: assert property (@(posedge clk) disable iff (!resetn) $onehot0(hit[m]))
            else $error("several slaves answered master %0d at once", m);
    end

endmodule

//--- verilog/xbar_top.sv
`timescale 1ns/100ps

module xbar_top import xbar_pkg::*; #(
    parameter int N_MASTERS  = 4,
    parameter int N_SLAVES   = 4,
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 4
)(
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic [N_MASTERS-1:0]                 master_req,
    input  logic [N_MASTERS-1:0][ADDR_WIDTH-1:0] master_addr,
    input  cmd_e [N_MASTERS-1:0]                 master_cmd,
    input  logic [N_MASTERS-1:0][DATA_WIDTH-1:0] master_wdata,
    output logic [N_MASTERS-1:0]                 master_ack,
    output logic [N_MASTERS-1:0]                 master_resp,
    output logic [N_MASTERS-1:0][DATA_WIDTH-1:0] master_rdata,
    output logic [N_SLAVES-1:0]                  slave_req,
    output logic [N_SLAVES-1:0][ADDR_WIDTH-1:0]  slave_addr,
    output cmd_e [N_SLAVES-1:0]                  slave_cmd,
    output logic [N_SLAVES-1:0][DATA_WIDTH-1:0]  slave_wdata,
    input  logic [N_SLAVES-1:0]                  slave_ack,
    input  logic [N_SLAVES-1:0]                  slave_resp,
    input  logic [N_SLAVES-1:0][DATA_WIDTH-1:0]  slave_rdata
);

    localparam int SID_W = $clog2(N_SLAVES);
    localparam int MID_W = $clog2(N_MASTERS);

    logic [N_MASTERS-1:0]                 pend_valid;
    logic [N_MASTERS-1:0][SID_W-1:0]      pend_sid;
    logic [N_MASTERS-1:0][ADDR_WIDTH-1:0] pend_addr;
    cmd_e [N_MASTERS-1:0]                 pend_cmd;
    logic [N_MASTERS-1:0][DATA_WIDTH-1:0] pend_wdata;
    logic [N_MASTERS-1:0]                 pend_take;
    logic [N_SLAVES-1:0][MID_W-1:0]       issue_mid;

    xbar_decode #(
        .N_MASTERS (N_MASTERS), .N_SLAVES (N_SLAVES),
        .ADDR_WIDTH (ADDR_WIDTH), .DATA_WIDTH (DATA_WIDTH)
    ) u_decode (
        .clk (clk), .resetn (resetn),
        .master_req (master_req), .master_addr (master_addr),
        .master_cmd (master_cmd), .master_wdata (master_wdata),
        .pend_take (pend_take), .master_resp (master_resp),
        .master_ack (master_ack), .pend_valid (pend_valid),
        .pend_sid (pend_sid), .pend_addr (pend_addr),
        .pend_cmd (pend_cmd), .pend_wdata (pend_wdata)
    );

    xbar_execute #(
        .N_MASTERS (N_MASTERS), .N_SLAVES (N_SLAVES),
        .ADDR_WIDTH (ADDR_WIDTH), .DATA_WIDTH (DATA_WIDTH)
    ) u_execute (
        .clk (clk), .resetn (resetn),
        .pend_valid (pend_valid), .pend_sid (pend_sid),
        .pend_addr (pend_addr), .pend_cmd (pend_cmd),
        .pend_wdata (pend_wdata), .slave_ack (slave_ack),
        .pend_take (pend_take), .slave_req (slave_req),
        .slave_addr (slave_addr), .slave_cmd (slave_cmd),
        .slave_wdata (slave_wdata), .issue_mid (issue_mid)
    );

    xbar_result #(
        .N_MASTERS (N_MASTERS), .N_SLAVES (N_SLAVES),
        .DATA_WIDTH (DATA_WIDTH), .FIFO_DEPTH (FIFO_DEPTH)
    ) u_result (
        .clk (clk), .resetn (resetn),
        .slave_req (slave_req), .slave_ack (slave_ack),
        .slave_cmd (slave_cmd), .issue_mid (issue_mid),
        .slave_resp (slave_resp), .slave_rdata (slave_rdata),
        .master_resp (master_resp), .master_rdata (master_rdata)
    );

endmodule

//--- testbench/tb_slave_model.sv
`timescale 1ns/100ps

module tb_slave_model import xbar_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
)(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  req,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  cmd_e                  cmd,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic                  ack,
    output logic                  resp,
    output logic [DATA_WIDTH-1:0] rdata
);

    logic [DATA_WIDTH-1:0] mem [16];
    logic [DATA_WIDTH-1:0] rd_q [$];

    // one request at a time, acked after a short random stall
    initial begin
        int stall;
        ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            ack = 1'b0;
            if (resetn && req) begin
                stall = $urandom_range(3, 0);
                repeat (stall) begin
                    @(posedge clk);
                    #2;
                end
                ack = 1'b1;
                @(negedge clk);
                // word index from the low address bits
                if (cmd == CMD_WRITE) begin
                    mem[addr[5:2]] = wdata;
                end else begin
                    rd_q.push_back(mem[addr[5:2]]);
                end
            end
        end
    end

    // read data goes back in ack order
    initial begin
        int delay;
        resp  = 1'b0;
        rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            resp = 1'b0;
            if (rd_q.size() > 0) begin
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge clk);
                #2;
                rdata = rd_q.pop_front();
                resp  = 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_xbar.sv
`timescale 1ns/100ps

module tb_xbar import xbar_pkg::*; ();

    localparam int N_MASTERS  = 4;
    localparam int N_SLAVES   = 4;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int FIFO_DEPTH = 4;
    localparam int N_ROWS     = 40;
    localparam int MAX_CYCLES = N_ROWS * 40;

    logic                                 clk;
    logic                                 resetn;
    logic [N_MASTERS-1:0]                 master_req;
    logic [N_MASTERS-1:0][ADDR_WIDTH-1:0] master_addr;
    cmd_e [N_MASTERS-1:0]                 master_cmd;
    logic [N_MASTERS-1:0][DATA_WIDTH-1:0] master_wdata;
    logic [N_MASTERS-1:0]                 master_ack;
    logic [N_MASTERS-1:0]                 master_resp;
    logic [N_MASTERS-1:0][DATA_WIDTH-1:0] master_rdata;
    logic [N_SLAVES-1:0]                  slave_req;
    logic [N_SLAVES-1:0][ADDR_WIDTH-1:0]  slave_addr;
    cmd_e [N_SLAVES-1:0]                  slave_cmd;
    logic [N_SLAVES-1:0][DATA_WIDTH-1:0]  slave_wdata;
    wire  [N_SLAVES-1:0]                  slave_ack;
    wire  [N_SLAVES-1:0]                  slave_resp;
    wire  [N_SLAVES-1:0][DATA_WIDTH-1:0]  slave_rdata;

    // stimulus table
    string                 row_name  [N_ROWS];
    int                    row_group [N_ROWS];
    int                    row_mst   [N_ROWS];
    int                    row_sid   [N_ROWS];
    logic [ADDR_WIDTH-1:0] row_addr  [N_ROWS];
    cmd_e                  row_cmd   [N_ROWS];
    logic [DATA_WIDTH-1:0] row_wdata [N_ROWS];
    logic [DATA_WIDTH-1:0] row_exp   [N_ROWS];
    int                    n_rows;

    logic [DATA_WIDTH-1:0] shadow [N_SLAVES][16];
    logic [N_MASTERS-1:0]  waiting;
    int                    cycles;

    // slave handshakes in the order they happened
    int                    seen_sid   [$];
    logic [ADDR_WIDTH-1:0] seen_addr  [$];
    cmd_e                  seen_cmd   [$];
    logic [DATA_WIDTH-1:0] seen_wdata [$];

    xbar_top #(
        .N_MASTERS (N_MASTERS), .N_SLAVES (N_SLAVES), .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH), .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (.*);

    for (genvar s = 0; s < N_SLAVES; s++) begin : gen_slave
        tb_slave_model #(
            .ADDR_WIDTH (ADDR_WIDTH), .DATA_WIDTH (DATA_WIDTH)
        ) u_slave (
            .clk (clk), .resetn (resetn), .req (slave_req[s]),
            .addr (slave_addr[s]), .cmd (slave_cmd[s]), .wdata (slave_wdata[s]),
            .ack (slave_ack[s]), .resp (slave_resp[s]), .rdata (slave_rdata[s])
        );
    end

    always #10 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // expected read data follows the shadow memory in table order
    function automatic void add_row(input string name, input int group, input int m,
                                    input int s, input int word, input cmd_e cmd);
        int r;
        r = n_rows;
        row_name[r]  = name;
        row_group[r] = group;
        row_mst[r]   = m;
        row_sid[r]   = s;
        row_addr[r]  = (ADDR_WIDTH'(s) << (ADDR_WIDTH - $clog2(N_SLAVES))) |
                       32'h0013_0000 | (ADDR_WIDTH'(word) << 2);
        row_cmd[r]   = cmd;
        row_wdata[r] = 32'h5A00_0000 ^ (DATA_WIDTH'(r) * 32'h0001_0307);
        if (cmd == CMD_WRITE) begin
            shadow[s][word] = row_wdata[r];
            row_exp[r]      = '0;
        end else begin
            row_exp[r] = shadow[s][word];
        end
        n_rows = r + 1;
    endfunction

    task automatic build_table();
        int g;
        g      = 0;
        n_rows = 0;
        for (int s = 0; s < N_SLAVES; s++) begin
            for (int m = 0; m < N_MASTERS; m++) begin
                add_row($sformatf("write m%0d s%0d", m, s), g, m, s, m, CMD_WRITE);
                g++;
            end
        end
        // read back words that another master wrote
        for (int m = 0; m < N_MASTERS; m++) begin
            add_row($sformatf("read m%0d s%0d", m, (m + 1) % 4), g, m, (m + 1) % 4,
                    (m + 2) % 4, CMD_READ);
            g++;
        end
        // all masters on slave 2 at once
        // odd rounds read back the even rounds
        for (int rnd = 0; rnd < 4; rnd++) begin
            for (int m = 0; m < N_MASTERS; m++) begin
                add_row($sformatf("rr round %0d m%0d", rnd, m), g, m, 2,
                        8 + 4 * (rnd / 2) + ((rnd % 2 == 1) ? (m + 1) % 4 : m),
                        cmd_e'(rnd % 2));
            end
            g++;
        end
        for (int m = 0; m < N_MASTERS; m++) begin
            add_row($sformatf("parallel m%0d s%0d", m, (m + 2) % 4), g, m, (m + 2) % 4,
                    3 - m, CMD_READ);
        end
    endtask

    // starts 2 ns after a rising edge
    task automatic run_row(input int r);
        int m;
        m = row_mst[r];
        master_req[m]   = 1'b1;
        master_addr[m]  = row_addr[r];
        master_cmd[m]   = row_cmd[r];
        master_wdata[m] = row_wdata[r];
        @(negedge clk);
        while (!master_ack[m]) @(negedge clk);
        @(posedge clk);
        #2;
        if (row_cmd[r] == CMD_WRITE) begin
            master_req[m] = 1'b0;
        end else begin
            // request stays up and must not be acked while the read is open
            waiting[m] = 1'b1;
            @(negedge clk);
            while (!master_resp[m]) begin
                check_value({row_name[r], " ack"}, 0, master_ack[m]);
                @(negedge clk);
            end
            check_value({row_name[r], " ack"}, 0, master_ack[m]);
            check_value(row_name[r], row_exp[r], master_rdata[m]);
            @(posedge clk);
            #2;
            master_req[m] = 1'b0;
            waiting[m]    = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        for (int s = 0; s < N_SLAVES; s++) begin
            if (resetn && slave_req[s] && slave_ack[s]) begin
                seen_sid.push_back(s);
                seen_addr.push_back(slave_addr[s]);
                seen_cmd.push_back(slave_cmd[s]);
                seen_wdata.push_back(slave_wdata[s]);
            end
        end
        for (int m = 0; m < N_MASTERS; m++) begin
            if (master_resp[m] && !waiting[m]) begin
                stop_with_failure($sformatf("master %0d got a response with no read open", m));
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            stop_with_failure($sformatf("timeout, run still going after %0d cycles",
                                        MAX_CYCLES));
        end
    end

    initial begin
        int i;
        int j;
        int base;
        int hits;
        int prior;
        clk          = 1'b0;
        resetn       = 1'b0;
        cycles       = 0;
        waiting      = '0;
        master_req   = '0;
        master_addr  = '0;
        master_wdata = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            master_cmd[m] = CMD_WRITE;
        end
        void'($urandom(32519));
        build_table();
        repeat (2) @(posedge clk);
        #2;
        resetn = 1'b1;
        @(negedge clk);
        check_value("reset slave_req", 0, slave_req);
        check_value("reset master_ack", 0, master_ack);
        check_value("reset master_resp", 0, master_resp);

        i = 0;
        while (i < n_rows) begin
            j = i;
            while (j < n_rows && row_group[j] == row_group[i]) j++;
            base = seen_sid.size();
            @(posedge clk);
            #2;
            for (int r = i; r < j; r++) begin
                automatic int rr = r;
                fork
                    run_row(rr);
                join_none
            end
            wait fork;
            // each row of the group reaches its slave exactly once
            while (seen_sid.size() < base + j - i) @(posedge clk);
            for (int r = i; r < j; r++) begin
                hits = 0;
                for (int e = base; e < seen_sid.size(); e++) begin
                    if (seen_addr[e] == row_addr[r]) begin
                        hits++;
                        check_value({row_name[r], " slave"}, row_sid[r], seen_sid[e]);
                        check_value({row_name[r], " cmd"}, row_cmd[r], seen_cmd[e]);
                        if (row_cmd[r] == CMD_WRITE) begin
                            check_value({row_name[r], " wdata"}, row_wdata[r], seen_wdata[e]);
                        end
                    end
                end
                check_value({row_name[r], " count"}, 1, hits);
            end
            // base of a shared slave moves by one per earlier grant there
            if (j - i == N_MASTERS && row_sid[i] == row_sid[j-1]) begin
                prior = 0;
                for (int e = 0; e < base; e++) begin
                    if (seen_sid[e] == row_sid[i]) begin
                        prior++;
                    end
                end
                for (int e = base; e < base + N_MASTERS; e++) begin
                    for (int r = i; r < j; r++) begin
                        if (seen_addr[e] == row_addr[r]) begin
                            check_value({row_name[r], " order"},
                                        (prior + e - base) % N_MASTERS, row_mst[r]);
                        end
                    end
                end
            end
            i = j;
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- project.f
verilog/xbar_pkg.sv
verilog/xbar_rr_arbiter.sv
verilog/xbar_id_fifo.sv
verilog/xbar_decode.sv
verilog/xbar_execute.sv
verilog/xbar_result.sv
verilog/xbar_top.sv
testbench/tb_slave_model.sv
testbench/tb_xbar.sv
